// File: src/cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Datapath and address width
`define XLEN 32

// Architectural register file
`define REG_COUNT 32
`define REG_AW ($clog2(`REG_COUNT))

// Memory sizes in words
`define IMEM_DEPTH 64
`define DMEM_DEPTH 64

// Word index widths, taken from address bits above bit 1
`define IMEM_AW ($clog2(`IMEM_DEPTH))
`define DMEM_AW ($clog2(`DMEM_DEPTH))

`endif

// File: src/cpu_pkg.sv
package cpu_pkg;

    // RV32I major opcodes in use, with their encodings
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011
    } opcodeT;

    // ALU operations
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASSB    // Operand B straight through, for LUI
    } aluOpT;

    // Operand source for EX
    typedef enum logic [1:0] {
        FWD_REG,     // Value read in decode
        FWD_MEM,     // ALU result sitting in EX/MEM
        FWD_WB       // Writeback value
    } fwdSelT;

endpackage

// File: src/fetch_stage.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module fetch_stage (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 stall,
    input  logic                 redirect,
    input  logic [`XLEN-1:0]     redirectPc,
    input  logic                 imemWe,
    input  logic [`IMEM_AW-1:0]  imemAddr,
    input  logic [`XLEN-1:0]     imemData,
    output logic                 ifIdValid,
    output logic [`XLEN-1:0]     ifIdInst,
    output logic [`XLEN-1:0]     ifIdPc
);

    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] imem [`IMEM_DEPTH];
    logic [`XLEN-1:0] fetchInst;

    // Program load port
    always_ff @(posedge clk) begin
        if (imemWe) begin
            imem[imemAddr] <= imemData;
        end
    end

    assign fetchInst = imem[pc[`IMEM_AW+1:2]];

    // Redirect wins over stall
    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= '0;
        end else if (redirect) begin
            pc <= redirectPc;
        end else if (!stall) begin
            pc <= pc + `XLEN'd4;
        end
    end

    // IF/ID register
    always_ff @(posedge clk) begin
        if (!rstN) begin
            ifIdValid <= 1'b0;
        end else if (redirect) begin
            ifIdValid <= 1'b0;                  // Flush younger instruction
        end else if (!stall) begin
            ifIdValid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall || redirect) begin
            ifIdInst <= fetchInst;
            ifIdPc   <= pc;
        end
    end

    // Load-use stall holds fetch for a single cycle only
    assert property (@(posedge clk) disable iff (!rstN)
        stall |=> !stall);

endmodule

// File: src/decode_stage.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module decode_stage (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 stall,
    input  logic                 redirect,
    input  logic                 ifIdValid,
    input  logic [`XLEN-1:0]     ifIdInst,
    input  logic [`XLEN-1:0]     ifIdPc,
    input  logic                 wbValid,
    input  logic [`REG_AW-1:0]   wbRd,
    input  logic [`XLEN-1:0]     wbData,
    output logic                 idExValid,
    output cpu_pkg::aluOpT       idExAluOp,
    output logic                 idExUseImm,
    output logic                 idExIsLoad,
    output logic                 idExIsStore,
    output logic                 idExIsBranch,
    output logic                 idExRegWrite,
    output logic [`REG_AW-1:0]   idExRs1,
    output logic [`REG_AW-1:0]   idExRs2,
    output logic [`REG_AW-1:0]   idExRd,
    output logic [`XLEN-1:0]     idExRdata1,
    output logic [`XLEN-1:0]     idExRdata2,
    output logic [`XLEN-1:0]     idExImm,
    output logic [`XLEN-1:0]     idExPc
);

    cpu_pkg::opcodeT     opcode;
    cpu_pkg::aluOpT      aluOp;
    logic                useImm, isLoad, isStore, isBranch, regWrite;
    logic [2:0]          funct3;
    logic [`REG_AW-1:0]  rs1, rs2, rd;
    logic [`XLEN-1:0]    imm, rdata1, rdata2;
    logic [`XLEN-1:0]    immI, immS, immB, immU;
    logic [`XLEN-1:0]    regs [`REG_COUNT];

    assign opcode = cpu_pkg::opcodeT'(ifIdInst[6:0]);
    assign rd     = ifIdInst[11:7];
    assign funct3 = ifIdInst[14:12];
    assign rs1    = ifIdInst[19:15];
    assign rs2    = ifIdInst[24:20];

    assign immI = {{20{ifIdInst[31]}}, ifIdInst[31:20]};
    assign immS = {{20{ifIdInst[31]}}, ifIdInst[31:25], ifIdInst[11:7]};
    assign immB = {{19{ifIdInst[31]}}, ifIdInst[31], ifIdInst[7],
                   ifIdInst[30:25], ifIdInst[11:8], 1'b0};
    assign immU = {ifIdInst[31:12], 12'b0};

    // Unknown encodings decode as a no-op
    always_comb begin
        aluOp    = cpu_pkg::ALU_ADD;
        useImm   = 1'b0;
        isLoad   = 1'b0;
        isStore  = 1'b0;
        isBranch = 1'b0;
        regWrite = 1'b0;
        imm      = immI;
        case (opcode)
            cpu_pkg::OP: begin
                regWrite = 1'b1;
                case (funct3)
                    3'b000:  aluOp = ifIdInst[30] ? cpu_pkg::ALU_SUB : cpu_pkg::ALU_ADD;
                    3'b010:  aluOp = cpu_pkg::ALU_SLT;
                    3'b100:  aluOp = cpu_pkg::ALU_XOR;
                    3'b110:  aluOp = cpu_pkg::ALU_OR;
                    3'b111:  aluOp = cpu_pkg::ALU_AND;
                    default: regWrite = 1'b0;
                endcase
            end
            cpu_pkg::OP_IMM: begin
                useImm   = 1'b1;
                regWrite = (funct3 == 3'b000);  // ADDI only
            end
            cpu_pkg::LUI: begin
                aluOp    = cpu_pkg::ALU_PASSB;
                useImm   = 1'b1;
                regWrite = 1'b1;
                imm      = immU;
            end
            cpu_pkg::LOAD: begin
                useImm   = 1'b1;
                isLoad   = 1'b1;
                regWrite = 1'b1;
            end
            cpu_pkg::STORE: begin
                useImm  = 1'b1;
                isStore = 1'b1;
                imm     = immS;
            end
            cpu_pkg::BRANCH: begin
                isBranch = (funct3 == 3'b000);  // BEQ
                imm      = immB;
            end
            default: ;
        endcase
    end

    // Register file, x0 has no storage behind it
    always_ff @(posedge clk) begin
        if (wbValid) begin
            regs[wbRd] <= wbData;
        end
    end

    // Write-through so a same-cycle writeback is seen
    always_comb begin
        if (rs1 == '0)                       rdata1 = '0;
        else if (wbValid && (wbRd == rs1))   rdata1 = wbData;
        else                                 rdata1 = regs[rs1];
        if (rs2 == '0)                       rdata2 = '0;
        else if (wbValid && (wbRd == rs2))   rdata2 = wbData;
        else                                 rdata2 = regs[rs2];
    end

    // ID/EX register, bubble on stall or flush
    always_ff @(posedge clk) begin
        if (!rstN) begin
            idExValid <= 1'b0;
        end else begin
            idExValid <= ifIdValid && !stall && !redirect;
        end
    end

    always_ff @(posedge clk) begin
        idExAluOp    <= aluOp;
        idExUseImm   <= useImm;
        idExIsLoad   <= isLoad;
        idExIsStore  <= isStore;
        idExIsBranch <= isBranch;
        idExRegWrite <= regWrite;
        idExRs1      <= rs1;
        idExRs2      <= rs2;
        idExRd       <= rd;
        idExRdata1   <= rdata1;
        idExRdata2   <= rdata2;
        idExImm      <= imm;
        idExPc       <= ifIdPc;
    end

    // Writeback from MEM/WB must never target x0
    assert property (@(posedge clk) disable iff (!rstN)
        wbValid |-> (wbRd != '0));

endmodule

// File: src/hazard_unit.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module hazard_unit (
    input  logic                 ifIdValid,
    input  logic [`XLEN-1:0]     ifIdInst,
    input  logic                 idExValid,
    input  logic                 idExIsLoad,
    input  logic [`REG_AW-1:0]   idExRd,
    input  logic [`REG_AW-1:0]   idExRs1,
    input  logic [`REG_AW-1:0]   idExRs2,
    input  logic                 exMemValid,
    input  logic                 exMemRegWrite,
    input  logic [`REG_AW-1:0]   exMemRd,
    input  logic                 wbValid,
    input  logic [`REG_AW-1:0]   wbRd,
    output logic                 stall,
    output cpu_pkg::fwdSelT      fwdA,
    output cpu_pkg::fwdSelT      fwdB
);

    logic [`REG_AW-1:0] idRs1, idRs2;

    assign idRs1 = ifIdInst[19:15];
    assign idRs2 = ifIdInst[24:20];

    // Load in EX feeding the instruction in decode; conservative on unused fields
    assign stall = ifIdValid && idExValid && idExIsLoad && (idExRd != '0)
                   && ((idExRd == idRs1) || (idExRd == idRs2));

    // MEM is younger than WB, so it wins
    function automatic cpu_pkg::fwdSelT pickSource(input logic [`REG_AW-1:0] rs);
        if (rs == '0)
            return cpu_pkg::FWD_REG;
        if (exMemValid && exMemRegWrite && (exMemRd == rs))
            return cpu_pkg::FWD_MEM;
        if (wbValid && (wbRd == rs))
            return cpu_pkg::FWD_WB;     // wbValid already excludes x0
        return cpu_pkg::FWD_REG;
    endfunction

    always_comb begin
        fwdA = pickSource(idExRs1);
        fwdB = pickSource(idExRs2);
    end

endmodule

// File: src/execute_stage.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module execute_stage (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 idExValid,
    input  cpu_pkg::aluOpT       idExAluOp,
    input  logic                 idExUseImm,
    input  logic                 idExIsLoad,
    input  logic                 idExIsStore,
    input  logic                 idExIsBranch,
    input  logic                 idExRegWrite,
    input  logic [`REG_AW-1:0]   idExRs1,
    input  logic [`REG_AW-1:0]   idExRs2,
    input  logic [`REG_AW-1:0]   idExRd,
    input  logic [`XLEN-1:0]     idExRdata1,
    input  logic [`XLEN-1:0]     idExRdata2,
    input  logic [`XLEN-1:0]     idExImm,
    input  logic [`XLEN-1:0]     idExPc,
    input  cpu_pkg::fwdSelT      fwdA,
    input  cpu_pkg::fwdSelT      fwdB,
    input  logic [`XLEN-1:0]     wbData,
    output logic                 redirect,
    output logic [`XLEN-1:0]     redirectPc,
    output logic                 exMemValid,
    output logic                 exMemIsLoad,
    output logic                 exMemIsStore,
    output logic                 exMemRegWrite,
    output logic [`REG_AW-1:0]   exMemRd,
    output logic [`XLEN-1:0]     exMemAluResult,
    output logic [`XLEN-1:0]     exMemStoreData
);

    logic [`XLEN-1:0] opA, opB, aluB, aluResult;

    // Forwarding muxes
    always_comb begin
        case (fwdA)
            cpu_pkg::FWD_MEM: opA = exMemAluResult;
            cpu_pkg::FWD_WB:  opA = wbData;
            default:          opA = idExRdata1;
        endcase
        case (fwdB)
            cpu_pkg::FWD_MEM: opB = exMemAluResult;
            cpu_pkg::FWD_WB:  opB = wbData;
            default:          opB = idExRdata2;
        endcase
    end

    assign aluB = idExUseImm ? idExImm : opB;

    always_comb begin
        case (idExAluOp)
            cpu_pkg::ALU_SUB:   aluResult = opA - aluB;
            cpu_pkg::ALU_AND:   aluResult = opA & aluB;
            cpu_pkg::ALU_OR:    aluResult = opA | aluB;
            cpu_pkg::ALU_XOR:   aluResult = opA ^ aluB;
            cpu_pkg::ALU_SLT:   aluResult = {{(`XLEN-1){1'b0}}, $signed(opA) < $signed(aluB)};
            cpu_pkg::ALU_PASSB: aluResult = aluB;
            default:            aluResult = opA + aluB;
        endcase
    end

    // BEQ resolves here
    assign redirect   = idExValid && idExIsBranch && (opA == opB);
    assign redirectPc = idExPc + idExImm;

    // EX/MEM register
    always_ff @(posedge clk) begin
        if (!rstN) begin
            exMemValid <= 1'b0;
        end else begin
            exMemValid <= idExValid;
        end
    end

    always_ff @(posedge clk) begin
        exMemIsLoad    <= idExIsLoad;
        exMemIsStore   <= idExIsStore;
        exMemRegWrite  <= idExRegWrite;
        exMemRd        <= idExRd;
        exMemAluResult <= aluResult;
        exMemStoreData <= opB;          // Forwarded rs2
    end

    // Taken branch comes from a live instruction and the slot behind it is flushed
    assert property (@(posedge clk) disable iff (!rstN)
        redirect |-> idExValid ##1 !idExValid);

endmodule

// File: src/memory_stage.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module memory_stage (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 exMemValid,
    input  logic                 exMemIsLoad,
    input  logic                 exMemIsStore,
    input  logic                 exMemRegWrite,
    input  logic [`REG_AW-1:0]   exMemRd,
    input  logic [`XLEN-1:0]     exMemAluResult,
    input  logic [`XLEN-1:0]     exMemStoreData,
    output logic                 wbValid,
    output logic [`REG_AW-1:0]   wbRd,
    output logic [`XLEN-1:0]     wbData
);

    logic [`XLEN-1:0]     dmem [`DMEM_DEPTH];
    logic [`DMEM_AW-1:0]  dAddr;
    logic [`XLEN-1:0]     loadData;

    assign dAddr = exMemAluResult[`DMEM_AW+1:2];   // Word index

    // Store lands at the edge ending MEM
    always_ff @(posedge clk) begin
        if (exMemValid && exMemIsStore) begin
            dmem[dAddr] <= exMemStoreData;
        end
    end

    assign loadData = dmem[dAddr];

    // MEM/WB register
    always_ff @(posedge clk) begin
        if (!rstN) begin
            wbValid <= 1'b0;
        end else begin
            wbValid <= exMemValid && exMemRegWrite && (exMemRd != '0);
        end
    end

    always_ff @(posedge clk) begin
        wbRd   <= exMemRd;
        wbData <= exMemIsLoad ? loadData : exMemAluResult;
    end

endmodule

// File: src/riscv_core.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module riscv_core (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 imemWe,
    input  logic [`IMEM_AW-1:0]  imemAddr,
    input  logic [`XLEN-1:0]     imemData,
    output logic                 retireValid,
    output logic [`REG_AW-1:0]   retireRd,
    output logic [`XLEN-1:0]     retireData
);

    logic                stall, redirect;
    logic [`XLEN-1:0]    redirectPc;
    logic                ifIdValid;
    logic [`XLEN-1:0]    ifIdInst, ifIdPc;
    logic                idExValid, idExUseImm, idExIsLoad, idExIsStore;
    logic                idExIsBranch, idExRegWrite;
    cpu_pkg::aluOpT      idExAluOp;
    logic [`REG_AW-1:0]  idExRs1, idExRs2, idExRd;
    logic [`XLEN-1:0]    idExRdata1, idExRdata2, idExImm, idExPc;
    cpu_pkg::fwdSelT     fwdA, fwdB;
    logic                exMemValid, exMemIsLoad, exMemIsStore, exMemRegWrite;
    logic [`REG_AW-1:0]  exMemRd;
    logic [`XLEN-1:0]    exMemAluResult, exMemStoreData;
    logic                wbValid;
    logic [`REG_AW-1:0]  wbRd;
    logic [`XLEN-1:0]    wbData;

    fetch_stage i_fetch (
        .clk, .rstN, .stall, .redirect, .redirectPc,
        .imemWe, .imemAddr, .imemData,
        .ifIdValid, .ifIdInst, .ifIdPc
    );

    decode_stage i_decode (
        .clk, .rstN, .stall, .redirect,
        .ifIdValid, .ifIdInst, .ifIdPc,
        .wbValid, .wbRd, .wbData,
        .idExValid, .idExAluOp, .idExUseImm, .idExIsLoad, .idExIsStore,
        .idExIsBranch, .idExRegWrite, .idExRs1, .idExRs2, .idExRd,
        .idExRdata1, .idExRdata2, .idExImm, .idExPc
    );

    hazard_unit i_hazard (
        .ifIdValid, .ifIdInst,
        .idExValid, .idExIsLoad, .idExRd, .idExRs1, .idExRs2,
        .exMemValid, .exMemRegWrite, .exMemRd,
        .wbValid, .wbRd,
        .stall, .fwdA, .fwdB
    );

    execute_stage i_execute (
        .clk, .rstN,
        .idExValid, .idExAluOp, .idExUseImm, .idExIsLoad, .idExIsStore,
        .idExIsBranch, .idExRegWrite, .idExRs1, .idExRs2, .idExRd,
        .idExRdata1, .idExRdata2, .idExImm, .idExPc,
        .fwdA, .fwdB, .wbData,
        .redirect, .redirectPc,
        .exMemValid, .exMemIsLoad, .exMemIsStore, .exMemRegWrite,
        .exMemRd, .exMemAluResult, .exMemStoreData
    );

    memory_stage i_memory (
        .clk, .rstN,
        .exMemValid, .exMemIsLoad, .exMemIsStore, .exMemRegWrite,
        .exMemRd, .exMemAluResult, .exMemStoreData,
        .wbValid, .wbRd, .wbData
    );

    // Retire port is the writeback itself
    assign retireValid = wbValid;
    assign retireRd    = wbRd;
    assign retireData  = wbData;

endmodule

// File: dv/tb_program.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

    // Row = instruction word, then the rd and value it should retire (rd 0 for none)
    task automatic buildTables();
        addRow(encI(cpu_pkg::OP_IMM, 3'b000, 5'd1, 5'd0, 12'd5), 5'd1, 32'd5);   // addi x1, x0, 5
        addRow(encI(cpu_pkg::OP_IMM, 3'b000, 5'd2, 5'd1, 12'd3), 5'd2, 32'd8);   // addi x2, x1, 3
        addRow(encR(7'h00, 3'b000, 5'd3, 5'd1, 5'd2), 5'd3, 32'd13);             // add  x3, x1, x2
        addRow(encR(7'h20, 3'b000, 5'd4, 5'd3, 5'd1), 5'd4, 32'd8);              // sub  x4, x3, x1
        addRow(encR(7'h00, 3'b100, 5'd5, 5'd4, 5'd3), 5'd5, 32'd5);              // xor  x5, x4, x3
        addRow(encR(7'h00, 3'b111, 5'd6, 5'd5, 5'd3), 5'd6, 32'd5);              // and  x6, x5, x3
        addRow(encR(7'h00, 3'b110, 5'd7, 5'd6, 5'd2), 5'd7, 32'd13);             // or   x7, x6, x2
        addRow(encR(7'h00, 3'b010, 5'd8, 5'd1, 5'd7), 5'd8, 32'd1);              // slt  x8, x1, x7
        addRow(encI(cpu_pkg::OP_IMM, 3'b000, 5'd9, 5'd0, 12'hff9), 5'd9, 32'hffff_fff9); // -7
        addRow(encR(7'h00, 3'b010, 5'd10, 5'd9, 5'd1), 5'd10, 32'd1);            // Signed compare
        addRow(encU(5'd11, 20'h12345), 5'd11, 32'h1234_5000);                    // lui  x11
        addRow(encI(cpu_pkg::OP_IMM, 3'b000, 5'd12, 5'd0, 12'd16), 5'd12, 32'd16);
        addRow(encS(5'd11, 5'd12, 12'd0), 5'd0, 32'd0);                          // sw   x11, 0(x12)
        addRow(encI(cpu_pkg::LOAD, 3'b010, 5'd13, 5'd12, 12'd0), 5'd13, 32'h1234_5000);
        addRow(encS(5'd7, 5'd12, 12'd4), 5'd0, 32'd0);                           // sw   x7, 4(x12)
        addRow(encI(cpu_pkg::LOAD, 3'b010, 5'd14, 5'd12, 12'd4), 5'd14, 32'd13);
        addRow(encR(7'h00, 3'b000, 5'd15, 5'd14, 5'd1), 5'd15, 32'd18);          // Load-use
        addRow(encB(5'd1, 5'd1, 13'd12), 5'd0, 32'd0);                           // Taken, to row 20
        addRow(encI(cpu_pkg::OP_IMM, 3'b000, 5'd16, 5'd0, 12'd1), 5'd0, 32'd0);  // Flushed
        addRow(encI(cpu_pkg::OP_IMM, 3'b000, 5'd16, 5'd0, 12'd2), 5'd0, 32'd0);  // Flushed
        addRow(encB(5'd1, 5'd2, 13'd8), 5'd0, 32'd0);                            // Not taken
        addRow(encI(cpu_pkg::OP_IMM, 3'b000, 5'd17, 5'd0, 12'd9), 5'd17, 32'd9);
        addRow(encI(cpu_pkg::OP_IMM, 3'b000, 5'd0, 5'd0, 12'd7), 5'd0, 32'd0);   // addi x0, x0, 7
        addRow(encR(7'h00, 3'b000, 5'd18, 5'd0, 5'd1), 5'd18, 32'd5);            // add  x18, x0, x1
        addRow(encB(5'd0, 5'd0, 13'd0), 5'd0, 32'd0);                            // Spin here
        addRow(encI(cpu_pkg::OP_IMM, 3'b000, 5'd0, 5'd0, 12'd0), 5'd0, 32'd0);   // nop
        addRow(encI(cpu_pkg::OP_IMM, 3'b000, 5'd0, 5'd0, 12'd0), 5'd0, 32'd0);   // nop
    endtask

`endif

// File: dv/core_tb.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module core_tb;

    localparam int resetCycles = 8;
    localparam int drainCycles = 12;

    logic                 clk = 1'b0;
    logic                 rstN;
    logic                 imemWe;
    logic [`IMEM_AW-1:0]  imemAddr;
    logic [`XLEN-1:0]     imemData;
    logic                 retireValid;
    logic [`REG_AW-1:0]   retireRd;
    logic [`XLEN-1:0]     retireData;

    logic [`XLEN-1:0]     progWords [$];
    logic [`REG_AW-1:0]   expRd [$];
    logic [`XLEN-1:0]     expData [$];
    int                   errorCount = 0;
    int                   missingCount = 0;
    int                   extraCount = 0;
    int                   retireIdx = 0;
    int                   edgeCount = 0;
    bit                   firstSeen = 1'b0;

    riscv_core i_dut (
        .clk, .rstN, .imemWe, .imemAddr, .imemData,
        .retireValid, .retireRd, .retireData
    );

    always #4 clk = ~clk;   // 8 ns period

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        if (got !== expected) begin
            errorCount++;
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, expected);
        end
    endtask

    // RV32I encoders
    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic [4:0] rd, rs1, rs2);
        return {f7, rs2, rs1, f3, rd, cpu_pkg::OP};
    endfunction

    function automatic logic [31:0] encI(input cpu_pkg::opcodeT opc, input logic [2:0] f3,
                                         input logic [4:0] rd, rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] encS(input logic [4:0] rs2, rs1, input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], cpu_pkg::STORE};
    endfunction

    function automatic logic [31:0] encB(input logic [4:0] rs1, rs2, input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], cpu_pkg::BRANCH};
    endfunction

    function automatic logic [31:0] encU(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, cpu_pkg::LUI};
    endfunction

    task automatic addRow(input logic [31:0] word, input logic [`REG_AW-1:0] rd,
                          input logic [31:0] value);
        progWords.push_back(word);
        if (rd != '0) begin
            expRd.push_back(rd);
            expData.push_back(value);
        end
    endtask

    task automatic printSummary();
        $display("Summary: %0d mismatches, %0d missing retires, %0d extra retires",
                 errorCount, missingCount, extraCount);
    endtask

    `include "tb_program.svh"

    // Retire port monitor
    always @(posedge clk) begin
        if (rstN) begin
            edgeCount++;
            if (retireValid) begin
                if (!firstSeen) begin
                    firstSeen = 1'b1;
                    // Fetch at edge 1, four stages later
                    checkValue("first retire edge", edgeCount, 32'd5);
                end
                if (retireIdx < expRd.size()) begin
                    checkValue("retireRd", 32'(retireRd), 32'(expRd[retireIdx]));
                    checkValue("retireData", retireData, expData[retireIdx]);
                    retireIdx++;
                end else begin
                    extraCount++;
                    $display("Unexpected retire of x%0d with value %h at %0t ns",
                             retireRd, retireData, $time);
                end
            end
        end
    end

    initial begin
        rstN     = 1'b0;
        imemWe   = 1'b0;
        imemAddr = '0;
        imemData = '0;
        buildTables();
        // Load port is only used while the core sits in reset
        foreach (progWords[i]) begin
            @(negedge clk);
            imemWe   = 1'b1;
            imemAddr = i[`IMEM_AW-1:0];
            imemData = progWords[i];
        end
        @(negedge clk);
        imemWe = 1'b0;
        repeat (resetCycles) @(negedge clk);
        rstN = 1'b1;
        wait (retireIdx == expRd.size());
        repeat (drainCycles) @(negedge clk);    // Catch stray retires
        printSummary();
        if (errorCount == 0 && extraCount == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // Watchdog
    initial begin
        int limit;
        @(posedge rstN);
        limit = progWords.size() * 4 + 20;
        repeat (limit) @(posedge clk);
        missingCount = expRd.size() - retireIdx;
        $display("Timeout after %0d cycles, %0d of %0d expected retires never appeared",
                 limit, missingCount, expRd.size());
        printSummary();
        $display("Finished with errors");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+src
+incdir+dv
src/cpu_pkg.sv
src/fetch_stage.sv
src/decode_stage.sv
src/hazard_unit.sv
src/execute_stage.sv
src/memory_stage.sv
src/riscv_core.sv
dv/core_tb.sv

// File: Makefile
# Verilator build and run for the pipelined core

VERILATOR ?= verilator
TOP       ?= core_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

PASS_MSG  := Finished with no errors
SOURCES   := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS   := $(wildcard src/*.svh dv/*.svh)
BIN       := $(OBJ_DIR)/$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR) -o $(TOP)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
